// File: tx_dsc_pkg.sv
`default_nettype none

// Queue, ring and host read request definitions for the TX descriptor engine.
package tx_dsc_pkg;

  // Queue table geometry.
  localparam int NB_QUEUES   = 16;
  localparam int QUEUE_ID_W  = 4;
  localparam int RING_PTR_W  = 11;
  // One bit wider than a pointer so a full 2048-entry ring can be expressed.
  localparam int RING_SIZE_W = 12;

  // Descriptor geometry.
  localparam int DSC_BYTES  = 64;
  localparam int DSC_DWORDS = 16;

  // Host read request fields.
  localparam int HOST_ADDR_W = 64;
  localparam int NB_DWORDS_W = 18;

  // FIFO sizing.
  localparam int JOB_FIFO_DEPTH  = 8;
  localparam int JOB_AFULL_LEVEL = 6;
  localparam int REQ_FIFO_DEPTH  = 8;
  localparam int REQ_AFULL_LEVEL = 5;

  // Job word, MSB first: queue id, head, tail, base address.
  localparam int JOB_W = QUEUE_ID_W + 2 * RING_PTR_W + HOST_ADDR_W;

  // Request word, MSB first: source address, dword count, queue id, tag head.
  localparam int REQ_W = HOST_ADDR_W + NB_DWORDS_W + QUEUE_ID_W + RING_PTR_W;

  // Request generator state.
  typedef enum logic {
    FETCH_IDLE,
    FETCH_WRAP
  } fetch_state_e;

endpackage

`default_nettype wire

// File: tx_apb_pkg.sv
`default_nettype none

// APB register map of the TX descriptor engine.
package tx_apb_pkg;

  localparam int APB_ADDR_W = 12;
  localparam int APB_DATA_W = 32;

  // Per-queue register pages, one word per queue.
  localparam logic [APB_ADDR_W-1:0] TAIL_BASE    = 12'h000;
  localparam logic [APB_ADDR_W-1:0] BASE_LO_BASE = 12'h100;
  localparam logic [APB_ADDR_W-1:0] BASE_HI_BASE = 12'h200;

  // Global configuration and statistics.
  localparam logic [APB_ADDR_W-1:0] RING_SIZE_ADDR   = 12'h300;
  localparam logic [APB_ADDR_W-1:0] DSC_REQ_CNT_ADDR = 12'h304;
  localparam logic [APB_ADDR_W-1:0] EMPTY_CNT_ADDR   = 12'h308;
  localparam logic [APB_ADDR_W-1:0] IGNORED_CNT_ADDR = 12'h30C;

  // Decoded register class.
  typedef enum logic [2:0] {
    REG_TAIL,
    REG_BASE_LO,
    REG_BASE_HI,
    REG_RING_SIZE,
    REG_DSC_REQ_CNT,
    REG_EMPTY_CNT,
    REG_IGNORED_CNT,
    REG_NONE
  } reg_sel_e;

endpackage

`default_nettype wire

// File: sync_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
  parameter int WIDTH       = 8,
  parameter int DEPTH       = 8,
  parameter int AFULL_LEVEL = 6
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             in_valid,
  output logic             in_ready,
  input  logic [WIDTH-1:0] in_data,
  output logic             out_valid,
  input  logic             out_ready,
  output logic [WIDTH-1:0] out_data,
  output logic             almost_full
);

  logic [WIDTH-1:0]           mem [DEPTH];
  logic [$clog2(DEPTH)-1:0]   wr_ptr;
  logic [$clog2(DEPTH)-1:0]   rd_ptr;
  logic [$clog2(DEPTH+1)-1:0] count;
  logic                       push;
  logic                       pop;

  // Flags come from the registered count only.
  assign in_ready    = (count != DEPTH[$clog2(DEPTH+1)-1:0]);
  assign out_valid   = (count != '0);
  assign almost_full = (count >= AFULL_LEVEL[$clog2(DEPTH+1)-1:0]);
  assign out_data    = mem[rd_ptr];

  assign push = in_valid && in_ready;
  assign pop  = out_valid && out_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == DEPTH[$clog2(DEPTH)-1:0] - 1'b1) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == DEPTH[$clog2(DEPTH)-1:0] - 1'b1) ? '0 : rd_ptr + 1'b1;
      end
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

  // Storage.
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= in_data;
    end
  end

  // Upstream must respect in_ready, so a full FIFO never sees a push.
  a_no_push_when_full: assert property (@(posedge clk) disable iff (rst)
    in_valid |-> in_ready);

endmodule

`default_nettype wire

// File: tx_regs_apb.sv
`timescale 1ns/1ps
`default_nettype none

module tx_regs_apb
  import tx_apb_pkg::*, tx_dsc_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst,

  // APB slave.
  input  logic                   psel,
  input  logic                   penable,
  input  logic                   pwrite,
  input  logic [APB_ADDR_W-1:0]  paddr,
  input  logic [APB_DATA_W-1:0]  pwdata,
  output logic [APB_DATA_W-1:0]  prdata,

  // Queue table writes.
  output logic                   tail_wr,
  output logic                   base_lo_wr,
  output logic                   base_hi_wr,
  output logic [QUEUE_ID_W-1:0]  wr_queue,
  output logic [APB_DATA_W-1:0]  wr_data,

  // Queue table reads.
  output logic [QUEUE_ID_W-1:0]  rd_queue,
  input  logic [RING_PTR_W-1:0]  rd_tail,
  input  logic [31:0]            rd_base_lo,
  input  logic [31:0]            rd_base_hi,

  // Configuration and statistics.
  output logic [RING_SIZE_W-1:0] ring_size,
  input  logic [31:0]            dsc_req_cnt,
  input  logic [31:0]            empty_cnt,
  input  logic [31:0]            ignored_cnt
);

  reg_sel_e                sel;
  logic [APB_ADDR_W-1:0]   word_addr;
  logic [APB_ADDR_W-1:0]   page_addr;
  logic [QUEUE_ID_W-1:0]   queue_idx;
  logic                    wr_en;

  //////////////////////////////////////////////////////////////////////
  // Address decode
  //////////////////////////////////////////////////////////////////////

  // Byte lanes are ignored, every register is a full word.
  assign word_addr = {paddr[APB_ADDR_W-1:2], 2'b00};
  assign page_addr = {paddr[APB_ADDR_W-1:QUEUE_ID_W+2], {(QUEUE_ID_W+2){1'b0}}};
  assign queue_idx = paddr[QUEUE_ID_W+1:2];

  always_comb begin
    if (page_addr == TAIL_BASE) begin
      sel = REG_TAIL;
    end else if (page_addr == BASE_LO_BASE) begin
      sel = REG_BASE_LO;
    end else if (page_addr == BASE_HI_BASE) begin
      sel = REG_BASE_HI;
    end else if (word_addr == RING_SIZE_ADDR) begin
      sel = REG_RING_SIZE;
    end else if (word_addr == DSC_REQ_CNT_ADDR) begin
      sel = REG_DSC_REQ_CNT;
    end else if (word_addr == EMPTY_CNT_ADDR) begin
      sel = REG_EMPTY_CNT;
    end else if (word_addr == IGNORED_CNT_ADDR) begin
      sel = REG_IGNORED_CNT;
    end else begin
      sel = REG_NONE;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Writes
  //////////////////////////////////////////////////////////////////////

  // A transfer completes in the access phase, one strobe per transfer.
  assign wr_en      = psel && penable && pwrite;
  assign tail_wr    = wr_en && (sel == REG_TAIL);
  assign base_lo_wr = wr_en && (sel == REG_BASE_LO);
  assign base_hi_wr = wr_en && (sel == REG_BASE_HI);
  assign wr_queue   = queue_idx;
  assign wr_data    = pwdata;

  always_ff @(posedge clk) begin
    if (rst) begin
      ring_size <= '0;
    end else if (wr_en && (sel == REG_RING_SIZE)) begin
      ring_size <= pwdata[RING_SIZE_W-1:0];
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Reads
  //////////////////////////////////////////////////////////////////////

  assign rd_queue = queue_idx;

  always_comb begin
    case (sel)
      REG_TAIL:        prdata = APB_DATA_W'(rd_tail);
      REG_BASE_LO:     prdata = rd_base_lo;
      REG_BASE_HI:     prdata = rd_base_hi;
      REG_RING_SIZE:   prdata = APB_DATA_W'(ring_size);
      REG_DSC_REQ_CNT: prdata = dsc_req_cnt;
      REG_EMPTY_CNT:   prdata = empty_cnt;
      REG_IGNORED_CNT: prdata = ignored_cnt;
      default:         prdata = '0;
    endcase
  end

  a_penable_needs_psel: assert property (@(posedge clk) disable iff (rst)
    penable |-> psel);

endmodule

`default_nettype wire

// File: tx_queue_table.sv
`timescale 1ns/1ps
`default_nettype none

module tx_queue_table
  import tx_dsc_pkg::*, tx_apb_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst,

  // Register writes.
  input  logic                  tail_wr,
  input  logic                  base_lo_wr,
  input  logic                  base_hi_wr,
  input  logic [QUEUE_ID_W-1:0] wr_queue,
  input  logic [APB_DATA_W-1:0] wr_data,

  // Register reads.
  input  logic [QUEUE_ID_W-1:0] rd_queue,
  output logic [RING_PTR_W-1:0] rd_tail,
  output logic [31:0]           rd_base_lo,
  output logic [31:0]           rd_base_hi,

  // Downstream fill levels.
  input  logic                  job_afull,
  input  logic                  req_afull,

  // Fetch jobs.
  output logic                  job_valid,
  output logic [JOB_W-1:0]      job_data,

  // Doorbell statistics.
  output logic [31:0]           empty_cnt,
  output logic [31:0]           ignored_cnt
);

  logic [RING_PTR_W-1:0] tails   [NB_QUEUES];
  logic [31:0]           base_lo [NB_QUEUES];
  logic [31:0]           base_hi [NB_QUEUES];
  logic [RING_PTR_W-1:0] new_tail;
  logic [RING_PTR_W-1:0] old_tail;
  logic                  accept;

  assign new_tail = wr_data[RING_PTR_W-1:0];
  assign old_tail = tails[wr_queue];

  // No room for a worst-case wrap downstream means the doorbell is dropped.
  assign accept = !job_afull && !req_afull;

  assign rd_tail    = tails[rd_queue];
  assign rd_base_lo = base_lo[rd_queue];
  assign rd_base_hi = base_hi[rd_queue];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < NB_QUEUES; i++) begin
        tails[i]   <= '0;
        base_lo[i] <= '0;
        base_hi[i] <= '0;
      end
      job_valid   <= 1'b0;
      empty_cnt   <= '0;
      ignored_cnt <= '0;
    end else begin
      job_valid <= 1'b0;
      if (tail_wr) begin
        if (!accept) begin
          ignored_cnt <= ignored_cnt + 1'b1;
        end else if (new_tail == old_tail) begin
          // Nothing new to fetch.
          empty_cnt <= empty_cnt + 1'b1;
        end else begin
          tails[wr_queue] <= new_tail;
          job_valid       <= 1'b1;
        end
      end
      if (base_lo_wr) begin
        base_lo[wr_queue] <= wr_data;
      end
      if (base_hi_wr) begin
        base_hi[wr_queue] <= wr_data;
      end
    end
  end

  // The previous tail becomes the head of this fetch.
  always_ff @(posedge clk) begin
    if (tail_wr) begin
      job_data <= {wr_queue, old_tail, new_tail, base_hi[wr_queue], base_lo[wr_queue]};
    end
  end

  a_no_job_after_reject: assert property (@(posedge clk) disable iff (rst)
    tail_wr && !accept |=> !job_valid);

endmodule

`default_nettype wire

// File: dsc_fetch_req_gen.sv
`timescale 1ns/1ps
`default_nettype none

module dsc_fetch_req_gen
  import tx_dsc_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst,
  input  logic [RING_SIZE_W-1:0] ring_size,

  // Fetch jobs.
  input  logic                   job_valid,
  output logic                   job_ready,
  input  logic [JOB_W-1:0]       job_data,

  // Host read requests.
  output logic                   req_push,
  input  logic                   req_push_ready,
  output logic [REQ_W-1:0]       req_data,

  output logic [31:0]            dsc_req_cnt
);

  fetch_state_e           state;
  logic                   req_pend;
  logic                   advance;
  logic                   take_job;
  logic                   wraps;

  logic [QUEUE_ID_W-1:0]  job_queue;
  logic [RING_PTR_W-1:0]  job_head;
  logic [RING_PTR_W-1:0]  job_tail;
  logic [HOST_ADDR_W-1:0] job_base;

  logic [RING_SIZE_W-1:0] first_dsc;
  logic [HOST_ADDR_W-1:0] first_addr;

  // Second half of a wrapping fetch.
  logic [QUEUE_ID_W-1:0]  wrap_queue;
  logic [RING_PTR_W-1:0]  wrap_tail;
  logic [HOST_ADDR_W-1:0] wrap_base;

  assign {job_queue, job_head, job_tail, job_base} = job_data;

  //////////////////////////////////////////////////////////////////////
  // First request of a job
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    if (job_tail > job_head) begin
      first_dsc = RING_SIZE_W'(job_tail) - RING_SIZE_W'(job_head);
    end else begin
      // Read up to the end of the ring.
      first_dsc = ring_size - RING_SIZE_W'(job_head);
    end
  end

  assign wraps      = (job_tail <= job_head) && (job_tail != '0);
  assign first_addr = job_base + HOST_ADDR_W'(job_head) * HOST_ADDR_W'(DSC_BYTES);

  //////////////////////////////////////////////////////////////////////
  // Output register
  //////////////////////////////////////////////////////////////////////

  // The output stage moves when empty or when its request is taken.
  assign advance   = !req_pend || req_push_ready;
  assign req_push  = req_pend && req_push_ready;
  assign job_ready = advance && (state == FETCH_IDLE);
  assign take_job  = job_valid && job_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      state       <= FETCH_IDLE;
      req_pend    <= 1'b0;
      dsc_req_cnt <= '0;
    end else if (advance) begin
      req_pend <= 1'b0;
      if (state == FETCH_WRAP) begin
        req_pend    <= 1'b1;
        state       <= FETCH_IDLE;
        dsc_req_cnt <= dsc_req_cnt + 32'(wrap_tail);
      end else if (take_job) begin
        req_pend    <= 1'b1;
        dsc_req_cnt <= dsc_req_cnt + 32'(first_dsc);
        if (wraps) begin
          state <= FETCH_WRAP;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (advance) begin
      if (state == FETCH_WRAP) begin
        // Restart at the ring base with tag head zero.
        req_data <= {wrap_base,
                     NB_DWORDS_W'(wrap_tail) * NB_DWORDS_W'(DSC_DWORDS),
                     wrap_queue,
                     {RING_PTR_W{1'b0}}};
      end else if (take_job) begin
        req_data   <= {first_addr,
                       NB_DWORDS_W'(first_dsc) * NB_DWORDS_W'(DSC_DWORDS),
                       job_queue,
                       job_head};
        wrap_queue <= job_queue;
        wrap_tail  <= job_tail;
        wrap_base  <= job_base;
      end
    end
  end

  // A job that waits while the second half of a wrap goes out stays at the FIFO head.
  a_no_job_in_wrap: assert property (@(posedge clk) disable iff (rst)
    state == FETCH_WRAP && job_valid |=> job_valid && $stable(job_data));

endmodule

`default_nettype wire

// File: tx_dsc_top.sv
`timescale 1ns/1ps
`default_nettype none

module tx_dsc_top
  import tx_dsc_pkg::*, tx_apb_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst,

  // APB slave.
  input  logic                   psel,
  input  logic                   penable,
  input  logic                   pwrite,
  input  logic [APB_ADDR_W-1:0]  paddr,
  input  logic [APB_DATA_W-1:0]  pwdata,
  output logic [APB_DATA_W-1:0]  prdata,

  // Host read requests.
  output logic                   req_valid,
  input  logic                   req_ready,
  output logic [HOST_ADDR_W-1:0] req_src_addr,
  output logic [NB_DWORDS_W-1:0] req_nb_dwords,
  output logic [QUEUE_ID_W-1:0]  req_queue_id,
  output logic [RING_PTR_W-1:0]  req_head
);

  logic                   tail_wr;
  logic                   base_lo_wr;
  logic                   base_hi_wr;
  logic [QUEUE_ID_W-1:0]  wr_queue;
  logic [APB_DATA_W-1:0]  wr_data;
  logic [QUEUE_ID_W-1:0]  rd_queue;
  logic [RING_PTR_W-1:0]  rd_tail;
  logic [31:0]            rd_base_lo;
  logic [31:0]            rd_base_hi;
  logic [RING_SIZE_W-1:0] ring_size;
  logic [31:0]            dsc_req_cnt;
  logic [31:0]            empty_cnt;
  logic [31:0]            ignored_cnt;

  logic                   job_afull;
  logic                   req_afull;
  logic                   tbl_job_valid;
  logic [JOB_W-1:0]       tbl_job_data;
  logic                   gen_job_valid;
  logic                   gen_job_ready;
  logic [JOB_W-1:0]       gen_job_data;
  logic                   req_push;
  logic                   req_push_ready;
  logic [REQ_W-1:0]       req_data;

  tx_regs_apb regs_i (
    .clk (clk), .rst (rst),
    .psel (psel), .penable (penable), .pwrite (pwrite),
    .paddr (paddr), .pwdata (pwdata), .prdata (prdata),
    .tail_wr (tail_wr), .base_lo_wr (base_lo_wr), .base_hi_wr (base_hi_wr),
    .wr_queue (wr_queue), .wr_data (wr_data),
    .rd_queue (rd_queue), .rd_tail (rd_tail),
    .rd_base_lo (rd_base_lo), .rd_base_hi (rd_base_hi),
    .ring_size (ring_size), .dsc_req_cnt (dsc_req_cnt),
    .empty_cnt (empty_cnt), .ignored_cnt (ignored_cnt)
  );

  tx_queue_table table_i (
    .clk (clk), .rst (rst),
    .tail_wr (tail_wr), .base_lo_wr (base_lo_wr), .base_hi_wr (base_hi_wr),
    .wr_queue (wr_queue), .wr_data (wr_data),
    .rd_queue (rd_queue), .rd_tail (rd_tail),
    .rd_base_lo (rd_base_lo), .rd_base_hi (rd_base_hi),
    .job_afull (job_afull), .req_afull (req_afull),
    .job_valid (tbl_job_valid), .job_data (tbl_job_data),
    .empty_cnt (empty_cnt), .ignored_cnt (ignored_cnt)
  );

  // Table pushes are pre-qualified by almost-full, so in_ready is not needed.
  sync_fifo #(
    .WIDTH (JOB_W), .DEPTH (JOB_FIFO_DEPTH), .AFULL_LEVEL (JOB_AFULL_LEVEL)
  ) job_fifo_i (
    .clk (clk), .rst (rst),
    .in_valid (tbl_job_valid), .in_ready (), .in_data (tbl_job_data),
    .out_valid (gen_job_valid), .out_ready (gen_job_ready), .out_data (gen_job_data),
    .almost_full (job_afull)
  );

  dsc_fetch_req_gen req_gen_i (
    .clk (clk), .rst (rst), .ring_size (ring_size),
    .job_valid (gen_job_valid), .job_ready (gen_job_ready), .job_data (gen_job_data),
    .req_push (req_push), .req_push_ready (req_push_ready), .req_data (req_data),
    .dsc_req_cnt (dsc_req_cnt)
  );

  sync_fifo #(
    .WIDTH (REQ_W), .DEPTH (REQ_FIFO_DEPTH), .AFULL_LEVEL (REQ_AFULL_LEVEL)
  ) req_fifo_i (
    .clk (clk), .rst (rst),
    .in_valid (req_push), .in_ready (req_push_ready), .in_data (req_data),
    .out_valid (req_valid), .out_ready (req_ready),
    .out_data ({req_src_addr, req_nb_dwords, req_queue_id, req_head}),
    .almost_full (req_afull)
  );

endmodule

`default_nettype wire

// File: tb_tx_dsc_tasks.svh
`ifndef TB_TX_DSC_TASKS_SVH
`define TB_TX_DSC_TASKS_SVH
`default_nettype none

//////////////////////////////////////////////////////////////////////
// APB driver
//////////////////////////////////////////////////////////////////////

task automatic apb_write(input logic [APB_ADDR_W-1:0] addr,
                         input logic [APB_DATA_W-1:0] data);
  @(negedge clk);
  psel    = 1'b1;
  penable = 1'b0;
  pwrite  = 1'b1;
  paddr   = addr;
  pwdata  = data;
  @(negedge clk);
  penable = 1'b1;
  @(negedge clk);
  psel    = 1'b0;
  penable = 1'b0;
endtask

task automatic apb_read(input logic [APB_ADDR_W-1:0] addr,
                        output logic [APB_DATA_W-1:0] data);
  @(negedge clk);
  psel    = 1'b1;
  penable = 1'b0;
  pwrite  = 1'b0;
  paddr   = addr;
  @(negedge clk);
  penable = 1'b1;
  // Sampled at the access-phase edge.
  @(posedge clk);
  data = prdata;
  @(negedge clk);
  psel    = 1'b0;
  penable = 1'b0;
endtask

function automatic int pick_below(input int limit);
  return int'($unsigned($random(seed)) % limit);
endfunction

//////////////////////////////////////////////////////////////////////
// Compare tasks
//////////////////////////////////////////////////////////////////////

task automatic check_reg(input string name, input logic [APB_DATA_W-1:0] got,
                         input logic [APB_DATA_W-1:0] want);
  if (got !== want) begin
    $display("ERROR %0t: register %s read 0x%08h, expected 0x%08h", $time, name, got, want);
    error_count++;
  end
endtask

task automatic check_req(input logic [HOST_ADDR_W-1:0] got_addr,
                         input logic [NB_DWORDS_W-1:0] got_nb,
                         input logic [QUEUE_ID_W-1:0]  got_qid,
                         input logic [RING_PTR_W-1:0]  got_head,
                         input logic [HOST_ADDR_W-1:0] want_addr,
                         input logic [NB_DWORDS_W-1:0] want_nb,
                         input logic [QUEUE_ID_W-1:0]  want_qid,
                         input logic [RING_PTR_W-1:0]  want_head);
  string got_s;
  string want_s;
  if (got_addr !== want_addr || got_nb !== want_nb ||
      got_qid !== want_qid || got_head !== want_head) begin
    got_s  = $sformatf("q%0d head %0d addr 0x%016h dwords %0d",
                       got_qid, got_head, got_addr, got_nb);
    want_s = $sformatf("q%0d head %0d addr 0x%016h dwords %0d",
                       want_qid, want_head, want_addr, want_nb);
    $display("ERROR %0t: request %s, expected %s", $time, got_s, want_s);
    error_count++;
  end
endtask

task automatic expect_reg(input string name, input logic [APB_ADDR_W-1:0] addr,
                          input logic [APB_DATA_W-1:0] want);
  logic [APB_DATA_W-1:0] data;
  apb_read(addr, data);
  check_reg(name, data, want);
endtask

//////////////////////////////////////////////////////////////////////
// Reference model
//////////////////////////////////////////////////////////////////////

task automatic push_expected(input logic [HOST_ADDR_W-1:0] addr, input int dsc,
                             input int q, input int head);
  exp_addr.push_back(addr);
  exp_nb.push_back(NB_DWORDS_W'(dsc * DSC_DWORDS));
  exp_qid.push_back(QUEUE_ID_W'(q));
  exp_head.push_back(RING_PTR_W'(head));
  m_dsc_cnt += dsc;
endtask

task automatic model_fetch(input int q, input int head, input int tail);
  logic [HOST_ADDR_W-1:0] start;
  start = m_base[q] + HOST_ADDR_W'(head * DSC_BYTES);
  if (tail > head) begin
    push_expected(start, tail - head, q, head);
  end else begin
    // Up to the ring end, then from the base if the tail moved past zero.
    push_expected(start, m_ring_size - head, q, head);
    if (tail != 0) begin
      push_expected(m_base[q], tail, q, 0);
    end
  end
endtask

// Writes a tail and reads it back to learn whether the doorbell was taken.
task automatic ring_doorbell(input int q, input int tail, input bit must_accept,
                             output bit accepted);
  logic [APB_ADDR_W-1:0] addr;
  logic [APB_DATA_W-1:0] data;
  addr = TAIL_BASE + APB_ADDR_W'(q * 4);
  apb_write(addr, APB_DATA_W'(tail));
  apb_read(addr, data);
  accepted = (data == APB_DATA_W'(tail));
  if (tail == m_tail[q]) begin
    m_empty_cnt++;
  end else if (accepted) begin
    model_fetch(q, m_tail[q], tail);
    m_tail[q] = tail;
  end else if (data == APB_DATA_W'(m_tail[q])) begin
    m_ignored_cnt++;
  end else begin
    $display("ERROR %0t: tail of queue %0d read %0d, expected %0d or %0d",
             $time, q, data, m_tail[q], tail);
    error_count++;
  end
  if (must_accept && !accepted) begin
    $display("Doorbell on queue %0d was rejected although the FIFOs had room", q);
    error_count++;
  end
endtask

// Waits for all expected requests, then idles to catch extra ones.
task automatic wait_drain();
  int waited;
  waited = 0;
  while (exp_addr.size() != 0 && waited < DRAIN_CYCLES) begin
    @(posedge clk);
    waited++;
  end
  if (exp_addr.size() != 0) begin
    $display("Missing requests: %0d expected host reads never appeared", exp_addr.size());
    error_count++;
    exp_addr.delete();
    exp_nb.delete();
    exp_qid.delete();
    exp_head.delete();
  end
  repeat (QUIET_CYCLES) @(posedge clk);
endtask

task automatic report_test(input string name);
  tests_done++;
  $display("Test %0d %s finished with %0d errors", tests_done, name,
           error_count - test_start_errors);
  test_start_errors = error_count;
endtask

//////////////////////////////////////////////////////////////////////
// Tests
//////////////////////////////////////////////////////////////////////

task automatic test_register_readback();
  logic [31:0] lo;
  logic [31:0] hi;
  bit          ok;
  for (int q = 0; q < NB_QUEUES; q++) begin
    expect_reg("tail", TAIL_BASE + APB_ADDR_W'(q * 4), '0);
    expect_reg("base_lo", BASE_LO_BASE + APB_ADDR_W'(q * 4), '0);
    expect_reg("base_hi", BASE_HI_BASE + APB_ADDR_W'(q * 4), '0);
  end
  expect_reg("ring_size", RING_SIZE_ADDR, '0);
  expect_reg("dsc_req_cnt", DSC_REQ_CNT_ADDR, '0);
  expect_reg("empty_cnt", EMPTY_CNT_ADDR, '0);
  expect_reg("ignored_cnt", IGNORED_CNT_ADDR, '0);
  // Nothing is mapped above the counters.
  expect_reg("unmapped", 12'h400, '0);

  for (int q = 0; q < NB_QUEUES; q++) begin
    lo = $random(seed) & 32'hFFFF_FFC0;
    hi = $random(seed);
    apb_write(BASE_LO_BASE + APB_ADDR_W'(q * 4), lo);
    apb_write(BASE_HI_BASE + APB_ADDR_W'(q * 4), hi);
    m_base[q] = {hi, lo};
  end
  apb_write(RING_SIZE_ADDR, APB_DATA_W'(TEST_RING_SIZE));
  m_ring_size = TEST_RING_SIZE;

  for (int q = 0; q < NB_QUEUES; q++) begin
    expect_reg("base_lo", BASE_LO_BASE + APB_ADDR_W'(q * 4), m_base[q][31:0]);
    expect_reg("base_hi", BASE_HI_BASE + APB_ADDR_W'(q * 4), m_base[q][63:32]);
  end
  expect_reg("ring_size", RING_SIZE_ADDR, APB_DATA_W'(TEST_RING_SIZE));
  ring_doorbell(0, 1 + pick_below(TEST_RING_SIZE - 1), 1'b1, ok);
  ring_doorbell(1, 1 + pick_below(TEST_RING_SIZE - 1), 1'b1, ok);
  wait_drain();
  report_test("register readback");
endtask

task automatic test_linear_doorbell();
  int t;
  bit ok;
  t = m_tail[2] + 1 + pick_below(100);
  ring_doorbell(2, t, 1'b1, ok);
  wait_drain();
  // The first tail becomes the head of the second fetch.
  t = m_tail[2] + 1 + pick_below(100);
  ring_doorbell(2, t, 1'b1, ok);
  wait_drain();
  report_test("linear doorbell");
endtask

task automatic test_wrap_doorbell();
  bit ok;
  ring_doorbell(4, 400 + pick_below(100), 1'b1, ok);
  wait_drain();
  ring_doorbell(4, 1 + pick_below(100), 1'b1, ok);
  wait_drain();
  // A tail back at zero needs only the read up to the ring end.
  ring_doorbell(5, 300 + pick_below(100), 1'b1, ok);
  wait_drain();
  ring_doorbell(5, 0, 1'b1, ok);
  wait_drain();
  report_test("wrap doorbell");
endtask

task automatic test_empty_doorbell();
  bit ok;
  expect_reg("empty_cnt", EMPTY_CNT_ADDR, APB_DATA_W'(m_empty_cnt));
  ring_doorbell(2, m_tail[2], 1'b1, ok);
  expect_reg("empty_cnt", EMPTY_CNT_ADDR, APB_DATA_W'(m_empty_cnt));
  ring_doorbell(2, m_tail[2], 1'b1, ok);
  expect_reg("empty_cnt", EMPTY_CNT_ADDR, APB_DATA_W'(m_empty_cnt));
  wait_drain();
  report_test("empty doorbell");
endtask

task automatic test_back_pressure();
  int t;
  int rejected;
  bit ok;
  rejected = 0;
  @(negedge clk);
  req_ready = 1'b0;
  for (int q = 0; q < NB_QUEUES; q++) begin
    t = (m_tail[q] + 1 + pick_below(m_ring_size - 1)) % m_ring_size;
    ring_doorbell(q, t, 1'b0, ok);
    if (!ok) begin
      rejected++;
    end
  end
  if (rejected == 0) begin
    $display("Back-pressure never caused a doorbell to be rejected");
    error_count++;
  end
  @(negedge clk);
  req_ready = 1'b1;
  wait_drain();
  expect_reg("ignored_cnt", IGNORED_CNT_ADDR, APB_DATA_W'(m_ignored_cnt));
  report_test("back-pressure");
endtask

task automatic test_request_counter();
  expect_reg("dsc_req_cnt", DSC_REQ_CNT_ADDR, APB_DATA_W'(m_dsc_cnt));
  report_test("request counter");
endtask

`default_nettype wire
`endif

// File: tb_tx_dsc.sv
`timescale 1ns/1ps
`default_nettype none

module tb_tx_dsc
  import tx_dsc_pkg::*, tx_apb_pkg::*;
();

  localparam int CLK_PERIOD          = 8;
  localparam int RESET_CYCLES        = 10;
  localparam int NB_TESTS            = 6;
  localparam int DOORBELLS_PER_TEST  = 16;
  localparam int CYCLES_PER_DOORBELL = 50;
  localparam int WATCHDOG_CYCLES     = NB_TESTS * DOORBELLS_PER_TEST * CYCLES_PER_DOORBELL;
  localparam int DRAIN_CYCLES        = 200;
  localparam int QUIET_CYCLES        = 10;
  localparam int TEST_RING_SIZE      = 512;

  logic                   clk;
  logic                   rst;
  logic                   psel;
  logic                   penable;
  logic                   pwrite;
  logic [APB_ADDR_W-1:0]  paddr;
  logic [APB_DATA_W-1:0]  pwdata;
  logic [APB_DATA_W-1:0]  prdata;
  logic                   req_valid;
  logic                   req_ready;
  logic [HOST_ADDR_W-1:0] req_src_addr;
  logic [NB_DWORDS_W-1:0] req_nb_dwords;
  logic [QUEUE_ID_W-1:0]  req_queue_id;
  logic [RING_PTR_W-1:0]  req_head;

  // Reference model state.
  int                     m_tail [NB_QUEUES];
  logic [HOST_ADDR_W-1:0] m_base [NB_QUEUES];
  int                     m_ring_size;
  int                     m_dsc_cnt;
  int                     m_empty_cnt;
  int                     m_ignored_cnt;

  // Expected host reads, oldest first.
  logic [HOST_ADDR_W-1:0] exp_addr [$];
  logic [NB_DWORDS_W-1:0] exp_nb   [$];
  logic [QUEUE_ID_W-1:0]  exp_qid  [$];
  logic [RING_PTR_W-1:0]  exp_head [$];

  integer                 seed;
  int                     error_count;
  int                     test_start_errors;
  int                     tests_done;

  tx_dsc_top dut_i (
    .clk (clk), .rst (rst),
    .psel (psel), .penable (penable), .pwrite (pwrite),
    .paddr (paddr), .pwdata (pwdata), .prdata (prdata),
    .req_valid (req_valid), .req_ready (req_ready),
    .req_src_addr (req_src_addr), .req_nb_dwords (req_nb_dwords),
    .req_queue_id (req_queue_id), .req_head (req_head)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  // Watchdog
  //////////////////////////////////////////////////////////////////////

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("ERRORS FOUND");
    $finish;
  end

  //////////////////////////////////////////////////////////////////////
  // Request monitor
  //////////////////////////////////////////////////////////////////////

  // Every accepted request is matched against the oldest expected one.
  always @(posedge clk) begin
    if (!rst && req_valid && req_ready) begin
      if (exp_addr.size() == 0) begin
        $display("Unexpected request at %0t for queue %0d with head %0d",
                 $time, req_queue_id, req_head);
        error_count++;
      end else begin
        check_req(req_src_addr, req_nb_dwords, req_queue_id, req_head,
                  exp_addr.pop_front(), exp_nb.pop_front(),
                  exp_qid.pop_front(), exp_head.pop_front());
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    rst       = 1'b1;
    psel      = 1'b0;
    penable   = 1'b0;
    pwrite    = 1'b0;
    paddr     = '0;
    pwdata    = '0;
    req_ready = 1'b1;

    seed              = 69;
    error_count       = 0;
    test_start_errors = 0;
    tests_done        = 0;
    m_ring_size       = 0;
    m_dsc_cnt         = 0;
    m_empty_cnt       = 0;
    m_ignored_cnt     = 0;
    for (int q = 0; q < NB_QUEUES; q++) begin
      m_tail[q] = 0;
      m_base[q] = '0;
    end

    repeat (RESET_CYCLES) @(negedge clk);
    rst = 1'b0;

    test_register_readback();
    test_linear_doorbell();
    test_wrap_doorbell();
    test_empty_doorbell();
    test_back_pressure();
    test_request_counter();

    $display("Tests run %0d, errors %0d", tests_done, error_count);
    if (error_count == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  `include "tb_tx_dsc_tasks.svh"

endmodule

`default_nettype wire

// File: all.f
+incdir+.
tx_dsc_pkg.sv
tx_apb_pkg.sv
sync_fifo.sv
tx_regs_apb.sv
tx_queue_table.sv
dsc_fetch_req_gen.sv
tx_dsc_top.sv
tb_tx_dsc.sv

// File: run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module tb_tx_dsc -f all.f &&
./obj_dir/Vtb_tx_dsc | tee /dev/stderr | grep -qx "NO ERRORS" &&
echo "PASS: simulation finished cleanly" ||
{ echo "FAIL: see simulation output above" >&2; exit 1; }
